/* biu_addr_gen.sv */
////////////////////
// ahb address phase registers and next beat address
////////////////////
`timescale 1ns/1ps
`default_nettype none

module biu_addr_gen (
  input  logic                         HCLK,
  input  logic                         HRESETn,
  biu_ahb_ctl_if.addr                  ctl,
  input  logic [biu_ahb_pkg::PLEN-1:0] biu_adri_i,
  input  logic [2:0]                   biu_size_i,
  input  biu_ahb_pkg::biu_type_e       biu_type_i,
  input  logic [2:0]                   biu_prot_i,
  input  logic                         biu_we_i,
  output logic [biu_ahb_pkg::PLEN-1:0] HADDR_o,
  output logic                         HWRITE_o,
  output logic [2:0]                   HSIZE_o,
  output biu_ahb_pkg::hburst_e         HBURST_o,
  output logic [3:0]                   HPROT_o
);

  logic [biu_ahb_pkg::PLEN-1:0] addr_inc;  // linear next word
  logic [biu_ahb_pkg::PLEN-1:0] addr_nxt;  // after wrap

  assign addr_inc = (HADDR_o + 32'd4) & ~32'd3;

  ////////////////////
  // wrap inside the aligned block
  ////////////////////
  always_comb begin
    case (HBURST_o)
      biu_ahb_pkg::HBURST_WRAP4:  addr_nxt = {HADDR_o[31:4], addr_inc[3:0]};  // 16 byte
      biu_ahb_pkg::HBURST_WRAP8:  addr_nxt = {HADDR_o[31:5], addr_inc[4:0]};  // 32 byte
      biu_ahb_pkg::HBURST_WRAP16: addr_nxt = {HADDR_o[31:6], addr_inc[5:0]};  // 64 byte
      default:                    addr_nxt = addr_inc;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      HADDR_o  <= '0;
      HWRITE_o <= 1'b0;
      HSIZE_o  <= biu_ahb_pkg::HSIZE_WORD;
      HBURST_o <= biu_ahb_pkg::HBURST_SINGLE;
      HPROT_o  <= biu_ahb_pkg::HPROT_RESET;
    end else if (ctl.load) begin
      // request attributes held for the whole burst
      HADDR_o  <= biu_adri_i;
      HWRITE_o <= biu_we_i;
      HSIZE_o  <= biu_ahb_pkg::biu_size2hsize(biu_size_i);
      HBURST_o <= biu_ahb_pkg::biu_type2hburst(biu_type_i);
      HPROT_o  <= biu_ahb_pkg::biu_prot2hprot(biu_prot_i);
    end else if (ctl.advance) begin
      HADDR_o  <= addr_nxt;  // seq beat
    end
  end

endmodule

`default_nettype wire

/* biu_ahb_ctl_if.sv */
////////////////////
// beat control from the sequencer to the counter, address and data blocks
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface biu_ahb_ctl_if;

  logic load;     // new burst, capture request
  logic advance;  // next seq beat
  logic abort;    // error response seen
  logic hready;   // forwarded HREADY
  logic last;     // no beats left

  modport fsm (
    output load, advance, abort, hready,
    input  last
  );

  modport cnt (
    input  load, advance, abort,
    output last
  );

  modport addr (
    input load, advance
  );

  modport data (
    input hready
  );

endinterface

`default_nettype wire

/* biu_ahb_fsm.sv */
////////////////////
// beat sequencer, takes core strobes and drives HTRANS, HSEL and the acks
////////////////////
`timescale 1ns/1ps
`default_nettype none

module biu_ahb_fsm (
  input  logic                        HCLK,
  input  logic                        HRESETn,
  biu_ahb_ctl_if.fsm                  ctl,
  input  logic                        biu_stb_i,
  input  logic                        biu_lock_i,
  input  logic                        HREADY_i,
  input  logic                        HRESP_i,
  input  logic [biu_ahb_pkg::XLEN-1:0] HRDATA_i,
  output logic                        biu_stb_ack_o,
  output logic                        biu_d_ack_o,
  output logic                        biu_ack_o,
  output logic [biu_ahb_pkg::XLEN-1:0] biu_q_o,
  output logic                        biu_err_o,
  output logic                        HSEL_o,
  output biu_ahb_pkg::htrans_e        HTRANS_o,
  output logic                        HMASTLOCK_o
);

  biu_ahb_pkg::fsm_state_e state;
  logic data_ena;    // address phase in flight
  logic data_ena_d;  // data phase in flight

  // control strobes
  assign biu_stb_ack_o = HREADY_i & ctl.last & biu_stb_i & ~biu_err_o;
  assign ctl.load      = biu_stb_ack_o;
  assign ctl.advance   = HREADY_i & ~ctl.last;
  assign ctl.abort     = ~HREADY_i & (HRESP_i == biu_ahb_pkg::HRESP_ERROR);
  assign ctl.hready    = HREADY_i;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state       <= biu_ahb_pkg::ST_IDLE;
      HTRANS_o    <= biu_ahb_pkg::HTRANS_IDLE;
      HMASTLOCK_o <= 1'b0;
      data_ena    <= 1'b0;
      biu_err_o   <= 1'b0;
    end else begin
      biu_err_o <= 1'b0;  // single cycle pulse
      if (HREADY_i) begin
        if (ctl.last) begin  // burst done, maybe start another
          HMASTLOCK_o <= biu_lock_i;
          if (ctl.load) begin
            state    <= biu_ahb_pkg::ST_BURST;
            HTRANS_o <= biu_ahb_pkg::HTRANS_NONSEQ;
            data_ena <= 1'b1;
          end else begin
            state    <= biu_ahb_pkg::ST_IDLE;
            HTRANS_o <= biu_ahb_pkg::HTRANS_IDLE;
            data_ena <= 1'b0;
          end
        end else begin
          HTRANS_o <= biu_ahb_pkg::HTRANS_SEQ;  // continue burst
          data_ena <= 1'b1;
        end
      end else if (ctl.abort) begin
        // first error cycle, drop the rest of the burst
        state     <= biu_ahb_pkg::ST_IDLE;
        HTRANS_o  <= biu_ahb_pkg::HTRANS_IDLE;
        data_ena  <= 1'b0;
        biu_err_o <= 1'b1;
      end
    end
  end

  // address phase moves into data phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      data_ena_d <= 1'b0;
    end else if (HREADY_i) begin
      data_ena_d <= data_ena;
    end
  end

  assign HSEL_o      = (state == biu_ahb_pkg::ST_BURST);
  assign biu_d_ack_o = HREADY_i & data_ena;    // addr phase accepted
  assign biu_ack_o   = HREADY_i & data_ena_d;  // data phase ends
  assign biu_q_o     = HRDATA_i;

endmodule

`default_nettype wire

/* biu_ahb_master.sv */
////////////////////
// biu to ahb-lite master, core strobe bus in and ahb-lite master ports out
////////////////////
`timescale 1ns/1ps
`default_nettype none

module biu_ahb_master (
  input  logic                         HCLK,
  input  logic                         HRESETn,
  // core side
  input  logic                         biu_stb_i,
  output logic                         biu_stb_ack_o,
  output logic                         biu_d_ack_o,
  input  logic [biu_ahb_pkg::PLEN-1:0] biu_adri_i,
  output logic [biu_ahb_pkg::PLEN-1:0] biu_adro_o,
  input  logic [2:0]                   biu_size_i,
  input  biu_ahb_pkg::biu_type_e       biu_type_i,
  input  logic [2:0]                   biu_prot_i,
  input  logic                         biu_lock_i,
  input  logic                         biu_we_i,
  input  logic [biu_ahb_pkg::XLEN-1:0] biu_d_i,
  output logic [biu_ahb_pkg::XLEN-1:0] biu_q_o,
  output logic                         biu_ack_o,
  output logic                         biu_err_o,
  // ahb-lite master
  output logic                         HSEL_o,
  output logic [biu_ahb_pkg::PLEN-1:0] HADDR_o,
  output logic [biu_ahb_pkg::XLEN-1:0] HWDATA_o,
  input  logic [biu_ahb_pkg::XLEN-1:0] HRDATA_i,
  output logic                         HWRITE_o,
  output logic [2:0]                   HSIZE_o,
  output logic [2:0]                   HBURST_o,
  output logic [3:0]                   HPROT_o,
  output logic [1:0]                   HTRANS_o,
  output logic                         HMASTLOCK_o,
  input  logic                         HREADY_i,
  input  logic                         HRESP_i
);

  biu_ahb_ctl_if u_ctl ();  // beat control bus

  biu_ahb_fsm u_fsm (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .ctl           (u_ctl.fsm),
    .biu_stb_i     (biu_stb_i),
    .biu_lock_i    (biu_lock_i),
    .HREADY_i      (HREADY_i),
    .HRESP_i       (HRESP_i),
    .HRDATA_i      (HRDATA_i),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .biu_ack_o     (biu_ack_o),
    .biu_q_o       (biu_q_o),
    .biu_err_o     (biu_err_o),
    .HSEL_o        (HSEL_o),
    .HTRANS_o      (HTRANS_o),
    .HMASTLOCK_o   (HMASTLOCK_o)
  );

  biu_burst_cnt u_burst_cnt (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .ctl        (u_ctl.cnt),
    .biu_type_i (biu_type_i)
  );

  biu_addr_gen u_addr_gen (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .ctl        (u_ctl.addr),
    .biu_adri_i (biu_adri_i),
    .biu_size_i (biu_size_i),
    .biu_type_i (biu_type_i),
    .biu_prot_i (biu_prot_i),
    .biu_we_i   (biu_we_i),
    .HADDR_o    (HADDR_o),
    .HWRITE_o   (HWRITE_o),
    .HSIZE_o    (HSIZE_o),
    .HBURST_o   (HBURST_o),
    .HPROT_o    (HPROT_o)
  );

  biu_data_pipe u_data_pipe (
    .HCLK       (HCLK),
    .ctl        (u_ctl.data),
    .biu_d_i    (biu_d_i),
    .HADDR_i    (HADDR_o),  // address echo source
    .HWDATA_o   (HWDATA_o),
    .biu_adro_o (biu_adro_o)
  );

endmodule

`default_nettype wire

/* biu_ahb_pkg.sv */
////////////////////
// widths, bus codes and request conversion helpers for the biu ahb-lite master
////////////////////
`default_nettype none

package biu_ahb_pkg;

  localparam int XLEN = 32;  // data width
  localparam int PLEN = 32;  // address width

  // core burst type
  typedef enum logic [2:0] {
    SINGLE = 3'd0, INCR  = 3'd1, WRAP4  = 3'd2, INCR4  = 3'd3,
    WRAP8  = 3'd4, INCR8 = 3'd5, WRAP16 = 3'd6, INCR16 = 3'd7
  } biu_type_e;

  // ahb burst codes
  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'd0, HBURST_INCR  = 3'd1, HBURST_WRAP4  = 3'd2, HBURST_INCR4  = 3'd3,
    HBURST_WRAP8  = 3'd4, HBURST_INCR8 = 3'd5, HBURST_WRAP16 = 3'd6, HBURST_INCR16 = 3'd7
  } hburst_e;

  typedef enum logic [1:0] {
    HTRANS_IDLE = 2'd0, HTRANS_BUSY = 2'd1, HTRANS_NONSEQ = 2'd2, HTRANS_SEQ = 2'd3
  } htrans_e;

  typedef enum logic {ST_IDLE, ST_BURST} fsm_state_e;  // beat sequencer

  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;

  localparam logic HRESP_ERROR = 1'b1;

  ////////////////////
  // hprot bits
  ////////////////////
  localparam logic [3:0] HPROT_OPCODE         = 4'b0000;
  localparam logic [3:0] HPROT_DATA           = 4'b0001;
  localparam logic [3:0] HPROT_USER           = 4'b0000;
  localparam logic [3:0] HPROT_PRIVILEGED     = 4'b0010;
  localparam logic [3:0] HPROT_NON_BUFFERABLE = 4'b0000;
  localparam logic [3:0] HPROT_NON_CACHEABLE  = 4'b0000;
  localparam logic [3:0] HPROT_CACHEABLE      = 4'b1000;
  localparam logic [3:0] HPROT_RESET          = HPROT_DATA | HPROT_PRIVILEGED |
                                                HPROT_NON_BUFFERABLE | HPROT_NON_CACHEABLE;

  // masks in core prot field
  localparam logic [2:0] PROT_DATA       = 3'b001;
  localparam logic [2:0] PROT_PRIVILEGED = 3'b010;
  localparam logic [2:0] PROT_CACHEABLE  = 3'b100;

  ////////////////////
  // conversions
  ////////////////////
  function automatic logic [3:0] biu_type2cnt(input biu_type_e t);
    case (t)
      WRAP4, INCR4:   return 4'd3;
      WRAP8, INCR8:   return 4'd7;
      WRAP16, INCR16: return 4'd15;
      default:        return 4'd0;  // single, incr run as one beat
    endcase
  endfunction

  function automatic hburst_e biu_type2hburst(input biu_type_e t);
    return hburst_e'(t);  // encodings line up one to one
  endfunction

  function automatic logic [2:0] biu_size2hsize(input logic [2:0] size);
    case (size)
      3'b000:  return HSIZE_BYTE;
      3'b001:  return HSIZE_HWORD;
      default: return HSIZE_WORD;  // dword folds to word at 32 bit
    endcase
  endfunction

  function automatic logic [3:0] biu_prot2hprot(input logic [2:0] prot);
    logic [3:0] hp;
    hp = |(prot & PROT_DATA) ? HPROT_DATA : HPROT_OPCODE;
    hp = hp | (|(prot & PROT_PRIVILEGED) ? HPROT_PRIVILEGED : HPROT_USER);
    hp = hp | (|(prot & PROT_CACHEABLE) ? HPROT_CACHEABLE : HPROT_NON_CACHEABLE);
    return hp | HPROT_NON_BUFFERABLE;
  endfunction

endpackage

`default_nettype wire

/* biu_burst_cnt.sv */
////////////////////
// remaining beat count of the active burst
////////////////////
`timescale 1ns/1ps
`default_nettype none

module biu_burst_cnt (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  biu_ahb_ctl_if.cnt             ctl,
  input  biu_ahb_pkg::biu_type_e biu_type_i
);

  logic [3:0] cnt;  // beats left minus one

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      cnt <= 4'd0;
    end else if (ctl.abort) begin
      cnt <= 4'd0;  // burst cut short
    end else if (ctl.load) begin
      cnt <= biu_ahb_pkg::biu_type2cnt(biu_type_i);
    end else if (ctl.advance) begin
      cnt <= cnt - 4'd1;
    end
  end

  // zero means the current beat is the last one
  assign ctl.last = (cnt == 4'd0);

endmodule

`default_nettype wire

/* biu_data_pipe.sv */
////////////////////
// write data delay to HWDATA and data phase address echo
////////////////////
`timescale 1ns/1ps
`default_nettype none

module biu_data_pipe (
  input  logic                         HCLK,
  biu_ahb_ctl_if.data                  ctl,
  input  logic [biu_ahb_pkg::XLEN-1:0] biu_d_i,
  input  logic [biu_ahb_pkg::PLEN-1:0] HADDR_i,
  output logic [biu_ahb_pkg::XLEN-1:0] HWDATA_o,
  output logic [biu_ahb_pkg::PLEN-1:0] biu_adro_o
);

  logic [biu_ahb_pkg::XLEN-1:0] biu_di_dly;  // data for next addr phase

  // stage 1, sampled in the ack cycle
  always_ff @(posedge HCLK) begin
    if (ctl.hready) begin
      biu_di_dly <= biu_d_i;
    end
  end

  ////////////////////
  // stage 2, data phase
  ////////////////////
  always_ff @(posedge HCLK) begin
    if (ctl.hready) begin
      HWDATA_o   <= biu_di_dly;  // holds through wait states
      biu_adro_o <= HADDR_i;     // goes with biu_q_o
    end
  end

endmodule

`default_nettype wire

/* flist.f */
biu_ahb_pkg.sv
biu_ahb_ctl_if.sv
biu_ahb_fsm.sv
biu_burst_cnt.sv
biu_addr_gen.sv
biu_data_pipe.sv
biu_ahb_master.sv
tb_biu_ahb_master.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the biu ahb master testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_biu_ahb_master -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1

/* tb_biu_ahb_master.sv */
////////////////////
// random core driver, ahb slave memory and reference model around the biu master
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_biu_ahb_master;

  localparam int NUM_REQ     = 300;
  localparam int WATCHDOG_NS = NUM_REQ * 16 * 4 * 10 + 20000;  // worst burst plus margin

  logic        HCLK, HRESETn;
  logic        biu_stb_i, biu_stb_ack_o, biu_d_ack_o, biu_ack_o, biu_err_o;
  logic [31:0] biu_adri_i, biu_adro_o, biu_d_i, biu_q_o;
  logic [2:0]  biu_size_i, biu_prot_i;
  logic        biu_lock_i, biu_we_i;
  biu_ahb_pkg::biu_type_e biu_type_i;
  logic        HSEL_o, HWRITE_o, HMASTLOCK_o, HREADY_i, HRESP_i;
  logic [31:0] HADDR_o, HWDATA_o, HRDATA_i;
  logic [2:0]  HSIZE_o, HBURST_o;
  logic [3:0]  HPROT_o;
  logic [1:0]  HTRANS_o;

  // request model
  int          issued, fail_count, n_beats, abeat, dbeat, d_idx;
  logic        req_active, req_acked, err_now;
  logic        addr_due;  // address phase expected on the bus
  logic [31:0] exp_addr [16];
  logic [31:0] wdata [16];
  // slave data phase
  logic        dp_valid, dp_write, dp_err, err_phase;
  logic [31:0] dp_addr;
  int          dp_beat, dp_wait;
  logic [31:0] mem [logic [31:0]];     // slave memory
  logic [31:0] shadow [logic [31:0]];  // expected contents

  biu_ahb_master u_biu_ahb_master (.*);

  always #5 HCLK = ~HCLK;

  ////////////////////
  // helpers
  ////////////////////
  task automatic check(input logic cond, input string what);
    assert (cond) else begin
      fail_count++;
      $display("MISMATCH at %0t ns: %s", $time, what);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopping at first error");
    end
  endtask

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;  // untouched words
  endfunction

  function automatic int beats_of(input biu_ahb_pkg::biu_type_e t);
    case (t)
      biu_ahb_pkg::WRAP4, biu_ahb_pkg::INCR4:   return 4;
      biu_ahb_pkg::WRAP8, biu_ahb_pkg::INCR8:   return 8;
      biu_ahb_pkg::WRAP16, biu_ahb_pkg::INCR16: return 16;
      default:                                  return 1;  // incr runs as single
    endcase
  endfunction

  // ahb spec burst codes
  function automatic logic [2:0] ahb_burst(input biu_ahb_pkg::biu_type_e t);
    case (t)
      biu_ahb_pkg::SINGLE: return 3'b000;
      biu_ahb_pkg::INCR:   return 3'b001;
      biu_ahb_pkg::WRAP4:  return 3'b010;
      biu_ahb_pkg::INCR4:  return 3'b011;
      biu_ahb_pkg::WRAP8:  return 3'b100;
      biu_ahb_pkg::INCR8:  return 3'b101;
      biu_ahb_pkg::WRAP16: return 3'b110;
      default:             return 3'b111;
    endcase
  endfunction

  function automatic logic [31:0] next_addr(input logic [31:0] a,
                                            input biu_ahb_pkg::biu_type_e t);
    logic [31:0] blk;
    logic [31:0] lin;
    blk = (t == biu_ahb_pkg::WRAP4) ? 32'd16 : (t == biu_ahb_pkg::WRAP8) ? 32'd32 :
          (t == biu_ahb_pkg::WRAP16) ? 32'd64 : 32'd0;
    lin = (a & ~32'd3) + 32'd4;
    if (blk == 32'd0) return lin;
    return (a & ~(blk - 32'd1)) | (lin & (blk - 32'd1));  // stay in block
  endfunction

  task automatic new_request();
    biu_type_i = biu_ahb_pkg::biu_type_e'(3'($urandom % 8));
    biu_we_i   = 1'($urandom % 2);
    biu_prot_i = 3'($urandom % 8);
    biu_lock_i = 1'($urandom % 2);
    biu_size_i = 3'($urandom % 4);
    biu_adri_i = 32'h0000_1000 + 32'(($urandom % 256) * 4);  // 1 KB window
    n_beats = beats_of(biu_type_i);
    exp_addr[0] = biu_adri_i;
    for (int i = 0; i < 16; i++) begin
      wdata[i] = $urandom;
      if (i > 0) exp_addr[i] = next_addr(exp_addr[i-1], biu_type_i);
    end
    req_active = 1'b1;
    req_acked  = 1'b0;
    abeat = 0;
    dbeat = 0;
    d_idx = 0;
    issued++;
  endtask

  ////////////////////
  // one clock cycle, driven at negedge, checked just after
  ////////////////////
  task automatic run_cycle();
    logic err_next;
    logic [31:0] rd;
    // slave response
    HRESP_i  = 1'b0;
    HREADY_i = 1'b1;
    HRDATA_i = $urandom;
    if (dp_valid && dp_wait > 0) begin
      HREADY_i = 1'b0;
    end else if (dp_valid && dp_err) begin
      HRESP_i  = 1'b1;
      HREADY_i = err_phase;  // two cycle error
    end else if (dp_valid && !dp_write) begin
      HRDATA_i = mem.exists(dp_addr) ? mem[dp_addr] : fill_word(dp_addr);
    end
    // core side
    biu_stb_i = req_active & ~req_acked;
    biu_d_i   = (d_idx < 16) ? wdata[d_idx] : 32'h0;
    #1;
    err_next = 1'b0;
    check(biu_err_o == err_now, $sformatf("biu_err_o %b expected %b", biu_err_o, err_now));
    check(biu_stb_ack_o == (HREADY_i & biu_stb_i & ~err_now), "biu_stb_ack_o wrong");
    check((HTRANS_o != 2'b00) == addr_due, $sformatf("HTRANS %0d, address phase expected %b",
          HTRANS_o, addr_due));
    check(HSEL_o == addr_due, "HSEL_o wrong");
    check(biu_d_ack_o == (HREADY_i & addr_due), "biu_d_ack_o wrong");
    check(biu_ack_o == (HREADY_i & dp_valid), "biu_ack_o wrong");
    if (dp_valid && dp_write && !dp_err)
      check(HWDATA_o == wdata[dp_beat], $sformatf("HWDATA %h expected %h beat %0d",
            HWDATA_o, wdata[dp_beat], dp_beat));
    // data phase end
    if (dp_valid && HREADY_i) begin
      if (dp_err) begin
        check(HTRANS_o == 2'b00 && !HSEL_o, "transfer still active after error");
        req_active = 1'b0;  // rest of burst dropped
      end else begin
        if (!dp_write) begin
          rd = shadow.exists(dp_addr) ? shadow[dp_addr] : fill_word(dp_addr);
          check(biu_q_o == rd, $sformatf("biu_q_o %h expected %h", biu_q_o, rd));
          check(biu_adro_o == dp_addr, $sformatf("biu_adro_o %h expected %h",
                biu_adro_o, dp_addr));
        end else begin
          mem[dp_addr]    = HWDATA_o;
          shadow[dp_addr] = wdata[dp_beat];
        end
        dbeat++;
        if (dbeat == n_beats) req_active = 1'b0;
      end
      dp_valid = 1'b0;
    end else if (dp_valid && !HREADY_i) begin
      if (HRESP_i) begin
        err_phase = 1'b1;
        err_next  = 1'b1;  // pulse follows first error cycle
        addr_due  = 1'b0;  // idle from next cycle
      end else begin
        dp_wait--;
      end
    end
    // address phase accepted
    if (HREADY_i && HTRANS_o != 2'b00) begin
      check(req_active && abeat < n_beats, "address phase beyond end of burst");
      check(HTRANS_o == ((abeat == 0) ? 2'b10 : 2'b11), $sformatf("HTRANS %0d beat %0d",
            HTRANS_o, abeat));
      check(HADDR_o == exp_addr[abeat], $sformatf("HADDR %h expected %h beat %0d",
            HADDR_o, exp_addr[abeat], abeat));
      check(HSIZE_o == ((biu_size_i < 3'd2) ? biu_size_i : 3'd2), "HSIZE wrong");
      check(HBURST_o == ahb_burst(biu_type_i), "HBURST wrong");
      check(HPROT_o == {biu_prot_i[2], 1'b0, biu_prot_i[1], biu_prot_i[0]}, "HPROT wrong");
      check(HMASTLOCK_o == biu_lock_i && HWRITE_o == biu_we_i, "HMASTLOCK or HWRITE wrong");
      dp_valid  = 1'b1;
      dp_addr   = HADDR_o;
      dp_write  = HWRITE_o;
      dp_beat   = abeat;
      dp_wait   = int'($urandom % 3);
      dp_err    = ($urandom % 100) < 3;
      err_phase = 1'b0;
      abeat++;
      addr_due  = (abeat < n_beats);  // seq beat follows
    end
    if (biu_stb_ack_o) begin
      req_acked = 1'b1;
      d_idx     = 1;
      addr_due  = 1'b1;  // nonseq in the next cycle
    end else if (biu_d_ack_o) begin
      d_idx++;  // next beat data
    end
    err_now = err_next;
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    void'($urandom(32'h4ff2c5ff));
    HCLK = 1'b0;
    HRESETn = 1'b0;
    biu_stb_i = 1'b0;
    biu_adri_i = '0;
    biu_size_i = '0;
    biu_type_i = biu_ahb_pkg::SINGLE;
    biu_prot_i = '0;
    biu_lock_i = 1'b0;
    biu_we_i = 1'b0;
    biu_d_i = '0;
    HRDATA_i = '0;
    HREADY_i = 1'b1;
    HRESP_i = 1'b0;
    issued = 0;
    fail_count = 0;
    req_active = 1'b0;
    req_acked = 1'b0;
    err_now = 1'b0;
    addr_due = 1'b0;
    dp_valid = 1'b0;
    n_beats = 0;
    repeat (5) @(negedge HCLK);
    HRESETn = 1'b1;
    @(negedge HCLK);
    #1;
    // idle state out of reset
    check(HTRANS_o == 2'b00 && !HSEL_o, "HTRANS not idle after reset");
    check(!biu_stb_ack_o && !biu_d_ack_o && !biu_ack_o && !biu_err_o, "ack high after reset");
    check(HPROT_o == 4'b0011, "HPROT not at reset value");
    while (issued < NUM_REQ || req_active) begin
      @(negedge HCLK);
      if (!req_active && issued < NUM_REQ) new_request();
      run_cycle();
    end
    if (fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: requests did not complete in the expected time");
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
